// ==== rtl/seq_settings.svh ====
`ifndef SEQ_SETTINGS_SVH
`define SEQ_SETTINGS_SVH

// program memory holds this many 32-bit words
`define SEQ_IMEM_DEPTH  64
`define SEQ_IMEM_ADDR_W 6

// data RAM word index width, so the RAM holds 256 words
`define SEQ_DMEM_ADDR_W 8

// word index of the first instruction after reset
`define SEQ_BOOT_ADDR   0

// pseudo peripherals sit outside the data RAM window, which is top nibble zero
`define SEQ_STDOUT_ADDR 32'h1000_0000
`define SEQ_EXIT_ADDR   32'h2000_0000

`endif

// ==== rtl/seq_pkg.sv ====
package seq_pkg;

    // 4-bit opcodes in the top nibble of every instruction
    // opcode 0 and anything above OP_BNE behave as a no-op
    localparam logic [3:0] OP_LUI  = 4'h1;
    localparam logic [3:0] OP_ADDI = 4'h2;
    localparam logic [3:0] OP_ADD  = 4'h3;
    localparam logic [3:0] OP_SUB  = 4'h4;
    localparam logic [3:0] OP_LW   = 4'h5;
    localparam logic [3:0] OP_SW   = 4'h6;
    localparam logic [3:0] OP_BNE  = 4'h7;

    // eight architectural registers where r0 reads as zero
    typedef logic [2:0] reg_idx_t;

    // the same word is read either as a register-register op or as an
    // op with a 16-bit immediate
    // the leading fields line up in both views
    typedef union packed {
        struct packed {
            logic [3:0]  opcode;
            reg_idx_t    rd;
            reg_idx_t    rs1;
            reg_idx_t    rs2;
            logic [18:0] pad;
        } rtype;
        struct packed {
            logic [3:0]  opcode;
            reg_idx_t    rd;
            reg_idx_t    rs1;
            logic [5:0]  pad;
            logic [15:0] imm;
        } itype;
    } instr_u;

endpackage

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/1ps

// data bus between the core and the memory block
// req is a single-cycle strobe and rvalid answers it exactly one cycle later
interface mem_bus_if;

    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rvalid;

    modport core (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  rvalid
    );

    modport mem (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output rvalid
    );

endinterface

// ==== rtl/instr_fetch.sv ====
`timescale 1ns/1ps
`include "seq_settings.svh"

module instr_fetch
    import seq_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_i,

    // program load port which is only used while fetch is disabled
    input  logic                         prog_we_i,
    input  logic [`SEQ_IMEM_ADDR_W-1:0]  prog_addr_i,
    input  logic [31:0]                  prog_data_i,

    // fetch request from the core
    input  logic                         fetch_req_i,
    input  logic [`SEQ_IMEM_ADDR_W-1:0]  pc_i,

    output instr_u                       instr_o,
    output logic                         instr_valid_o
);

    logic [31:0] imem_q [`SEQ_IMEM_DEPTH];
    logic        valid_q;
    instr_u      instr_q;

    // the load port has its own write path into the program memory
    always_ff @(posedge clk_i) begin
        if (prog_we_i) begin
            imem_q[prog_addr_i] <= prog_data_i;
        end
    end

    // the word is only updated on a fetch, so it stays stable while the
    // core waits on a data access
    always_ff @(posedge clk_i) begin
        if (fetch_req_i) begin
            instr_q <= imem_q[pc_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_req_i;
        end
    end

    assign instr_o       = instr_q;
    assign instr_valid_o = valid_q;

    // the program must not be rewritten while the core is fetching from it
    a_no_load_during_fetch: assert property (
        @(posedge clk_i) disable iff (rst_i)
        fetch_req_i |-> !prog_we_i
    ) else $error("program load while a fetch is requested");

endmodule

// ==== rtl/seq_core.sv ====
`timescale 1ns/1ps
`include "seq_settings.svh"

module seq_core
    import seq_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         fetch_enable_i,

    output logic                         fetch_req_o,
    output logic [`SEQ_IMEM_ADDR_W-1:0]  pc_o,
    input  instr_u                       instr_i,
    input  logic                         instr_valid_i,

    mem_bus_if.core                      bus
);

    localparam int PC_W = `SEQ_IMEM_ADDR_W;

    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;

    logic [1:0]      state_q;
    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_next;
    logic [31:0]     rf_q [8];

    logic [31:0]     rs1_val;
    logic [31:0]     rs2_val;
    logic [31:0]     rd_val;
    logic [31:0]     imm_sext;
    logic [31:0]     alu_res;
    logic            alu_we;
    logic            is_mem;
    logic            exec_go;

    // a load keeps its destination here while the memory answers
    logic            ld_q;
    reg_idx_t        ld_rd_q;

    // r0 reads as zero whatever the register file holds for it
    assign rs1_val  = (instr_i.itype.rs1 == '0) ? '0 : rf_q[instr_i.itype.rs1];
    assign rs2_val  = (instr_i.rtype.rs2 == '0) ? '0 : rf_q[instr_i.rtype.rs2];
    assign rd_val   = (instr_i.itype.rd == '0) ? '0 : rf_q[instr_i.itype.rd];
    assign imm_sext = {{16{instr_i.itype.imm[15]}}, instr_i.itype.imm};

    assign exec_go  = (state_q == ST_EXEC) && instr_valid_i;

    always_comb begin
        alu_we  = 1'b0;
        alu_res = '0;
        is_mem  = 1'b0;
        pc_next = pc_q + PC_W'(1);
        case (instr_i.itype.opcode)
            OP_LUI: begin
                alu_we  = 1'b1;
                alu_res = {instr_i.itype.imm, 16'h0000};
            end
            OP_ADDI: begin
                alu_we  = 1'b1;
                alu_res = rs1_val + imm_sext;
            end
            OP_ADD: begin
                alu_we  = 1'b1;
                alu_res = rs1_val + rs2_val;
            end
            OP_SUB: begin
                alu_we  = 1'b1;
                alu_res = rs1_val - rs2_val;
            end
            OP_LW, OP_SW: begin
                is_mem = 1'b1;
            end
            OP_BNE: begin
                // the pc wraps at the memory depth, so the low bits of the
                // offset are all that matter
                if (rd_val != rs1_val) begin
                    pc_next = pc_q + imm_sext[PC_W-1:0];
                end
            end
            default: begin
            end
        endcase
    end

    assign fetch_req_o = (state_q == ST_FETCH) && fetch_enable_i;
    assign pc_o        = pc_q;

    assign bus.req   = exec_go && is_mem;
    assign bus.we    = (instr_i.itype.opcode == OP_SW);
    assign bus.addr  = rs1_val + imm_sext;
    assign bus.wdata = rd_val;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_FETCH;
            pc_q    <= PC_W'(`SEQ_BOOT_ADDR);
            ld_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    if (fetch_enable_i) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (instr_valid_i) begin
                        if (is_mem) begin
                            state_q <= ST_MEM;
                            ld_q    <= (instr_i.itype.opcode == OP_LW);
                        end else begin
                            state_q <= ST_FETCH;
                            pc_q    <= pc_next;
                        end
                    end
                end
                ST_MEM: begin
                    if (bus.rvalid) begin
                        state_q <= ST_FETCH;
                        pc_q    <= pc_q + PC_W'(1);
                    end
                end
                default: state_q <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (exec_go && is_mem) begin
            ld_rd_q <= instr_i.itype.rd;
        end
    end

    // the register file is written either from the ALU or from a returning load
    always_ff @(posedge clk_i) begin
        if (exec_go && alu_we) begin
            rf_q[instr_i.itype.rd] <= alu_res;
        end else if ((state_q == ST_MEM) && bus.rvalid && ld_q) begin
            rf_q[ld_rd_q] <= bus.rdata;
        end
    end

    // the memory must answer the next cycle, and no second request may
    // be issued in the meantime
    a_one_outstanding: assert property (
        @(posedge clk_i) disable iff (rst_i)
        bus.req |=> (bus.rvalid && !bus.req)
    ) else $error("data request issued while one is outstanding");

    // the fetched word for the current pc must land while the core executes
    a_instr_in_exec: assert property (
        @(posedge clk_i) disable iff (rst_i)
        instr_valid_i |-> (state_q == ST_EXEC)
    ) else $error("instruction arrived outside the execute state");

endmodule

// ==== rtl/mm_ram.sv ====
`timescale 1ns/1ps
`include "seq_settings.svh"

module mm_ram (
    input  logic        clk_i,
    input  logic        rst_i,

    mem_bus_if.mem      bus,

    output logic        stdout_valid_o,
    output logic [7:0]  stdout_char_o,
    output logic        exit_valid_o,
    output logic [31:0] exit_value_o,
    output logic        tests_passed_o,
    output logic        tests_failed_o
);

    localparam int DMEM_W = `SEQ_DMEM_ADDR_W;

    logic [31:0]       ram_q [2**DMEM_W];

    // the request as captured on the req cycle
    logic              req_q;
    logic              we_q;
    logic [31:0]       addr_q;
    logic [31:0]       wdata_q;

    logic              sel_ram;
    logic              sel_stdout;
    logic              sel_exit;
    logic [DMEM_W-1:0] ram_idx;

    logic              exit_valid_q;
    logic [31:0]       exit_value_q;
    logic              passed_q;
    logic              failed_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= bus.req;
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            we_q    <= bus.we;
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end
    end

    // anything with a zero top nibble lands in the word-addressed RAM
    assign sel_ram    = (addr_q[31:28] == 4'h0);
    assign sel_stdout = (addr_q == `SEQ_STDOUT_ADDR);
    assign sel_exit   = (addr_q == `SEQ_EXIT_ADDR);
    assign ram_idx    = addr_q[DMEM_W+1:2];

    always_ff @(posedge clk_i) begin
        if (req_q && we_q && sel_ram) begin
            ram_q[ram_idx] <= wdata_q;
        end
    end

    // peripherals and unmapped space read back as zero
    assign bus.rdata  = sel_ram ? ram_q[ram_idx] : '0;
    assign bus.rvalid = req_q;

    assign stdout_valid_o = req_q && we_q && sel_stdout;
    assign stdout_char_o  = wdata_q[7:0];

    // only the first exit write counts and later ones are ignored until reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exit_valid_q <= 1'b0;
            exit_value_q <= '0;
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
        end else if (req_q && we_q && sel_exit && !exit_valid_q) begin
            exit_valid_q <= 1'b1;
            exit_value_q <= wdata_q;
            passed_q     <= (wdata_q == '0);
            failed_q     <= (wdata_q != '0);
        end
    end

    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;

    a_pass_fail_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(tests_passed_o && tests_failed_o)
    ) else $error("tests_passed_o and tests_failed_o both high");

    // the RAM is word addressed and drops the two low address bits
    a_ram_aligned: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (bus.req && (bus.addr[31:28] == 4'h0)) |-> (bus.addr[1:0] == 2'b00)
    ) else $error("unaligned data RAM access");

endmodule

// ==== rtl/seq_wrapper.sv ====
`timescale 1ns/1ps
`include "seq_settings.svh"

// harness around the sequencer core, with program memory on the input side
// and data RAM plus pseudo peripherals on the output side
module seq_wrapper
    import seq_pkg::*;
(
    input  logic                         clk_i,
    input  logic                         rst_i,

    input  logic                         fetch_enable_i,
    input  logic                         prog_we_i,
    input  logic [`SEQ_IMEM_ADDR_W-1:0]  prog_addr_i,
    input  logic [31:0]                  prog_data_i,

    output logic                         stdout_valid_o,
    output logic [7:0]                   stdout_char_o,
    output logic                         exit_valid_o,
    output logic [31:0]                  exit_value_o,
    output logic                         tests_passed_o,
    output logic                         tests_failed_o
);

    logic                         fetch_req;
    logic [`SEQ_IMEM_ADDR_W-1:0]  pc;
    instr_u                       instr;
    logic                         instr_valid;

    mem_bus_if data_bus ();

    instr_fetch fetch_i (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .prog_we_i      ( prog_we_i      ),
        .prog_addr_i    ( prog_addr_i    ),
        .prog_data_i    ( prog_data_i    ),
        .fetch_req_i    ( fetch_req      ),
        .pc_i           ( pc             ),
        .instr_o        ( instr          ),
        .instr_valid_o  ( instr_valid    )
    );

    seq_core core_i (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .fetch_enable_i ( fetch_enable_i ),
        .fetch_req_o    ( fetch_req      ),
        .pc_o           ( pc             ),
        .instr_i        ( instr          ),
        .instr_valid_i  ( instr_valid    ),
        .bus            ( data_bus.core  )
    );

    mm_ram ram_i (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .bus            ( data_bus.mem   ),
        .stdout_valid_o ( stdout_valid_o ),
        .stdout_char_o  ( stdout_char_o  ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o )
    );

endmodule

// ==== tb/tb_seq_wrapper.sv ====
`timescale 1ns/1ps
`include "seq_settings.svh"

module tb_seq_wrapper;

    localparam int TDATA_WORDS     = 128;
    localparam int IMEM_AW         = `SEQ_IMEM_ADDR_W;
    localparam int CYCLES_PER_WORD = 40 * 8;

    logic                clk_i;
    logic                rst_i;
    logic                fetch_enable_i;
    logic                prog_we_i;
    logic [IMEM_AW-1:0]  prog_addr_i;
    logic [31:0]         prog_data_i;
    logic                stdout_valid_o;
    logic [7:0]          stdout_char_o;
    logic                exit_valid_o;
    logic [31:0]         exit_value_o;
    logic                tests_passed_o;
    logic                tests_failed_o;

    logic [31:0] tdata [TDATA_WORDS];
    logic [7:0]  chars_q [$];
    int          rd_ptr;
    int          error_cnt;
    int          check_cnt;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    seq_wrapper u_dut (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .fetch_enable_i ( fetch_enable_i ),
        .prog_we_i      ( prog_we_i      ),
        .prog_addr_i    ( prog_addr_i    ),
        .prog_data_i    ( prog_data_i    ),
        .stdout_valid_o ( stdout_valid_o ),
        .stdout_char_o  ( stdout_char_o  ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // the limit stays at zero until the test data has been sized
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // holds reset for five clock cycles with fetch disabled
    task automatic reset_dut();
        @(negedge clk_i);
        rst_i          = 1'b1;
        fetch_enable_i = 1'b0;
        prog_we_i      = 1'b0;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
    endtask

    task automatic load_program(input int len);
        for (int i = 0; i < len; i++) begin
            @(negedge clk_i);
            prog_we_i   = 1'b1;
            prog_addr_i = IMEM_AW'(i);
            prog_data_i = tdata[rd_ptr + i];
        end
        @(negedge clk_i);
        prog_we_i = 1'b0;
    endtask

    // entered on a falling edge, so fetch_enable_i changes there as well
    task automatic run_until_exit();
        chars_q.delete();
        fetch_enable_i = 1'b1;
        do begin
            @(negedge clk_i);
            if (stdout_valid_o) begin
                chars_q.push_back(stdout_char_o);
            end
        end while (!exit_valid_o);
        fetch_enable_i = 1'b0;
    endtask

    initial begin
        int          n_tests;
        int          len;
        int          n_chars;
        int          errors_before;
        int          p;
        logic [31:0] exp_exit;

        rst_i          = 1'b1;
        fetch_enable_i = 1'b0;
        prog_we_i      = 1'b0;
        prog_addr_i    = '0;
        prog_data_i    = '0;
        error_cnt      = 0;
        check_cnt      = 0;

        $readmemh("tb/seq_testdata.hex", tdata);
        n_tests = int'(tdata[0]);

        // walk the records once to work out how long the whole run may take
        p = 1;
        for (int t = 0; t < n_tests; t++) begin
            len = int'(tdata[p]);
            cycle_limit += len * CYCLES_PER_WORD;
            p += len + 2;
            p += int'(tdata[p]) + 1;
        end

        rd_ptr = 1;
        for (int t = 0; t < n_tests; t++) begin
            errors_before = error_cnt;
            len = int'(tdata[rd_ptr]);
            rd_ptr++;
            reset_dut();
            load_program(len);
            rd_ptr += len;
            exp_exit = tdata[rd_ptr];
            n_chars  = int'(tdata[rd_ptr + 1]);
            rd_ptr += 2;

            check_equal(32'(exit_valid_o), 32'h0, "exit_valid_o before fetch");
            check_equal(32'(tests_passed_o), 32'h0, "tests_passed_o before fetch");
            check_equal(32'(tests_failed_o), 32'h0, "tests_failed_o before fetch");
            check_equal(32'(stdout_valid_o), 32'h0, "stdout_valid_o before fetch");

            run_until_exit();

            // a zero exit value means passed, anything else means failed
            check_equal(exit_value_o, exp_exit, "exit_value_o");
            check_equal(32'(tests_passed_o), 32'(exp_exit == 32'h0), "tests_passed_o");
            check_equal(32'(tests_failed_o), 32'(exp_exit != 32'h0), "tests_failed_o");
            check_equal(32'(chars_q.size()), 32'(n_chars), "stdout character count");
            for (int i = 0; i < n_chars; i++) begin
                if (i < chars_q.size()) begin
                    check_equal(32'(chars_q[i]), tdata[rd_ptr + i],
                                $sformatf("stdout character %0d", i));
                end
            end
            rd_ptr += n_chars;

            $display("test %0d: %s, %0d mismatches", t + 1,
                     (error_cnt == errors_before) ? "ok" : "failed",
                     error_cnt - errors_before);
        end

        $display("%0d tests, %0d checks, %0d mismatches", n_tests, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb/seq_testdata.hex ====
// word 0 is the number of tests, then per test: program length, program words,
// expected exit value, expected stdout character count, one word per character
4
// test 1, arithmetic with LUI, ADDI, ADD and SUB plus one unknown opcode
0000000A
12001234 22400056 24000100 36500000
2800FFFE F3FFFFFF 4AE00000 1C002000
6B800000 7C000000
// non-zero exit value, so tests_failed_o goes high
12340158
00000000
// test 2, three words stored and loaded back, exit 1 on any mismatch
00000013
22000123 1400BEEF 24800042 2600FFFF
62000010 64000014 660003FC
58000010 5A000014 5C0003FC
1E002000 78400005 7A800004 7CC00003
// pass path exits with zero and spins, fail path exits with one
61C00000 7E000000
28000001 69C00000 7E000000
00000000
00000000
// test 3, BNE countdown from four printing A to D
0000000A
22000004 24000041 16001000 18002000
64C00000 24800001 2240FFFF 7200FFFD
61000000 78000000
00000000
00000004
00000041 00000042 00000043 00000044
// test 4, stdout takes the low byte, exit and stdout read back as zero
0000000C
1200ABCD 2240125A 16001000 18002000
62C00000 2A000077 5B000000 5CC00000
2D80004B 6CC00000 6B000000 78000000
00000000
00000002
0000005A 0000004B

// ==== sim.f ====
+incdir+rtl
rtl/seq_pkg.sv
rtl/mem_bus_if.sv
rtl/instr_fetch.sv
rtl/seq_core.sv
rtl/mm_ram.sv
rtl/seq_wrapper.sv
tb/tb_seq_wrapper.sv

// ==== Makefile ====
# Verilator build and run for the sequencer harness
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_seq_wrapper
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, and decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "No errors" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
